//--- logic/vlane_alu.sv
/* First lane stage. Registers the wrapped alu result with its saturate op, mask bit
   and operand a. Loads only on valid and holds otherwise. No overflow reporting.
*/
`timescale 1ns/1ps

module vlane_alu (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   valid,     // issue strobe for this element
  input  vlane_pkg::alu_op_e     alu_op,
  input  vlane_pkg::sat_op_e     sat_op,
  input  logic                   mask,      // lane enable bit
  input  vlane_pkg::lane_req_t   elem,
  output vlane_pkg::lane_stage_t stage
);

  import vlane_pkg::*;

  logic [ELEM_W-1:0] sum_ab;                // a + b
  logic [ELEM_W-1:0] diff_ab;               // a - b
  logic [ELEM_W-1:0] diff_ba;               // b - a
  logic [ELEM_W-1:0] result;                // selected, not yet registered
  lane_stage_t       stage_d;               // next stage contents

  // all three candidates in parallel, carries dropped
  assign sum_ab  = elem.a + elem.b;
  assign diff_ab = elem.a - elem.b;
  assign diff_ba = elem.b - elem.a;

  always_comb begin
    case (alu_op)
      ALU_ADD:  result = sum_ab;
      ALU_SUB:  result = diff_ab;
      ALU_RSUB: result = diff_ba;
      default:  result = elem.a;            // ALU_PASS
    endcase
  end

  // pack everything stage 2 needs
  always_comb begin
    stage_d        = '0;
    stage_d.result = result;
    stage_d.sat_op = sat_op;
    stage_d.mask   = mask;
    stage_d.a      = elem.a;                // kept for masked-off lanes
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage <= '0;
    end else if (valid) begin
      stage <= stage_d;                     // hold between strobes
    end
  end

endmodule

//--- logic/vlane_lane.sv
/* One vector lane. Alu stage, then clamp and mask merge into the output register.
   Two cycles from valid to out_word. stage_valid must be valid delayed by one cycle.
*/
`timescale 1ns/1ps

module vlane_lane (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         valid,        // issue strobe
  input  logic                         stage_valid,  // valid delayed one cycle
  input  vlane_pkg::alu_op_e           alu_op,
  input  vlane_pkg::sat_op_e           sat_op,
  input  logic                         mask,
  input  vlane_pkg::lane_req_t         elem,
  output logic [vlane_pkg::ELEM_W-1:0] out_word
);

  import vlane_pkg::*;

  lane_stage_t       stage;                 // stage 1 register
  logic [ELEM_W-1:0] sat_word;              // clamped alu result
  logic [ELEM_W-1:0] merged;                // after mask select

  vlane_alu i_vlane_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .valid  (valid),
    .alu_op (alu_op),
    .sat_op (sat_op),
    .mask   (mask),
    .elem   (elem),
    .stage  (stage)
  );

  vlane_saturatesize i_vlane_saturatesize (
    .in_word  (stage.result),
    .op       (stage.sat_op),
    .out_word (sat_word)
  );

  assign merged = stage.mask ? sat_word : stage.a;  // disabled lane returns a

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_word <= '0;
    end else if (stage_valid) begin
      out_word <= merged;
    end
  end

  // issuer must only send the nine defined clamp codes
  a_legal_sat_op: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> sat_op inside {SAT_U_W, SAT_U_B, SAT_U_H,
                             SAT_S_W, SAT_S_B, SAT_S_H,
                             SAT_SU_W, SAT_SU_B, SAT_SU_H});

endmodule

//--- logic/vlane_pkg.sv
/* Shared types for the vector lane slice. Saturate encodings assume 32-bit elements,
   so ELEM_W must stay 32. Opcodes outside the nine legal sat codes behave as unsigned.
*/
package vlane_pkg;

  // element and issue geometry
  localparam int ELEM_W    = 32;                 // one word per element
  localparam int NUM_LANES = 4;                  // lanes per issue
  localparam int SAT_OP_W  = 4;                  // saturate opcode width
  localparam int ALU_OP_W  = 2;                  // alu opcode width

  // clamp limits, sign-extended to the full element
  localparam logic [ELEM_W-1:0] S8_MAX  = 32'h0000_007f;  // +127
  localparam logic [ELEM_W-1:0] S8_MIN  = 32'hffff_ff80;  // -128
  localparam logic [ELEM_W-1:0] U8_MAX  = 32'h0000_00ff;  // 255
  localparam logic [ELEM_W-1:0] S16_MAX = 32'h0000_7fff;  // +32767
  localparam logic [ELEM_W-1:0] S16_MIN = 32'hffff_8000;  // -32768
  localparam logic [ELEM_W-1:0] U16_MAX = 32'h0000_ffff;  // 65535
  localparam logic [ELEM_W-1:0] ZERO_W  = '0;             // floor for signed to unsigned

  // size field of the saturate opcode, bits 1:0
  localparam logic [1:0] SZ_WORD = 2'b00;
  localparam logic [1:0] SZ_BYTE = 2'b01;
  localparam logic [1:0] SZ_HALF = 2'b10;

  // saturate opcode
  // bit 3 output signed, bit 2 input signed, bits 1:0 size
  typedef enum logic [SAT_OP_W-1:0] {
    SAT_U_W  = 4'b0000,   // pass through
    SAT_U_B  = 4'b0001,
    SAT_U_H  = 4'b0010,
    SAT_SU_W = 4'b0100,   // negative to zero
    SAT_SU_B = 4'b0101,
    SAT_SU_H = 4'b0110,
    SAT_S_W  = 4'b1100,   // pass through
    SAT_S_B  = 4'b1101,
    SAT_S_H  = 4'b1110
  } sat_op_e;

  // element alu opcode, all ops wrap mod 2^32
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_PASS = 2'b00,     // a
    ALU_ADD  = 2'b01,     // a + b
    ALU_SUB  = 2'b10,     // a - b
    ALU_RSUB = 2'b11      // b - a
  } alu_op_e;

  // operands of one lane element
  typedef struct packed {
    logic [ELEM_W-1:0] a;                        // also the masked-off return value
    logic [ELEM_W-1:0] b;
  } lane_req_t;

  // per-issue control, common to all lanes
  typedef struct packed {
    alu_op_e               alu_op;
    sat_op_e               sat_op;
    logic [NUM_LANES-1:0]  mask;                 // 1 = lane enabled
  } vec_req_t;

  // stage 1 to stage 2 register contents of one lane
  typedef struct packed {
    logic [ELEM_W-1:0] result;                   // wrapped alu result
    sat_op_e           sat_op;                   // carried for the clamp
    logic              mask;                     // lane enable
    logic [ELEM_W-1:0] a;                        // original operand a
  } lane_stage_t;

endpackage

//--- logic/vlane_satlanes.sv
/* Top of the lane slice. One strobe issues one element to each of NUM_LANES lanes.
   Results come exactly two cycles later. No ready and no back-pressure.
*/
`timescale 1ns/1ps

module vlane_satlanes (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,     // one-cycle issue strobe
  input  vlane_pkg::vec_req_t          in_ctrl,      // shared ops and lane mask
  input  vlane_pkg::lane_req_t         in_elem  [vlane_pkg::NUM_LANES],
  output logic                         out_valid,
  output logic [vlane_pkg::ELEM_W-1:0] out_elem [vlane_pkg::NUM_LANES]
);

  import vlane_pkg::*;

  logic stage_valid;                        // in_valid delayed one cycle

  // two-flop valid pipeline, matches the lane depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
      out_valid   <= 1'b0;
    end else begin
      stage_valid <= in_valid;
      out_valid   <= stage_valid;
    end
  end

  // same ops to every lane, one mask bit each
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    vlane_lane i_vlane_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .valid       (in_valid),
      .stage_valid (stage_valid),
      .alu_op      (in_ctrl.alu_op),
      .sat_op      (in_ctrl.sat_op),
      .mask        (in_ctrl.mask[i]),
      .elem        (in_elem[i]),
      .out_word    (out_elem[i])
    );
  end

  // fixed latency, every strobe shows up two edges later
  a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n, 2) |-> out_valid == $past(in_valid, 2));

endmodule

//--- logic/vlane_saturatesize.sv
/* Combinational clamp of a 32-bit value to signed or unsigned byte, half or word.
   Only valid for 32-bit input. Word size passes through except SAT_SU_W.
*/
`timescale 1ns/1ps

module vlane_saturatesize (
  input  logic [vlane_pkg::ELEM_W-1:0] in_word,
  input  vlane_pkg::sat_op_e           op,
  output logic [vlane_pkg::ELEM_W-1:0] out_word
);

  import vlane_pkg::*;

  logic [SAT_OP_W-1:0] op_bits;
  logic                out_signed;          // op bit 3
  logic                in_signed;           // op bit 2
  logic [1:0]          size;                // op bits 1:0
  logic                neg;                 // sign bit of a signed read
  logic                s8_hi;               // positive, above +127
  logic                s8_lo;               // negative, below -128
  logic                u8_over;             // unsigned, above 255
  logic                su8_over;            // positive, above 255
  logic                s16_hi;
  logic                s16_lo;
  logic                u16_over;
  logic                su16_over;

  assign op_bits    = op;
  assign out_signed = op_bits[3];
  assign in_signed  = op_bits[2];
  assign size       = op_bits[1:0];

  assign neg = in_word[ELEM_W-1];

  // byte range checks, upper bits must all match the sign
  assign s8_hi    = ~neg & (|in_word[ELEM_W-2:7]);
  assign s8_lo    = neg & ~(&in_word[ELEM_W-2:7]);
  assign u8_over  = |in_word[ELEM_W-1:8];
  assign su8_over = |in_word[ELEM_W-2:8];   // only looked at when not negative

  // half range checks
  assign s16_hi    = ~neg & (|in_word[ELEM_W-2:15]);
  assign s16_lo    = neg & ~(&in_word[ELEM_W-2:15]);
  assign u16_over  = |in_word[ELEM_W-1:16];
  assign su16_over = |in_word[ELEM_W-2:16];

  always_comb begin
    out_word = in_word;                     // in range or word pass
    case (size)
      SZ_BYTE: begin
        case ({in_signed, out_signed})
          2'b11:   out_word = s8_hi ? S8_MAX : (s8_lo ? S8_MIN : in_word);
          2'b10:   out_word = neg ? ZERO_W : (su8_over ? U8_MAX : in_word);
          default: out_word = u8_over ? U8_MAX : in_word;
        endcase
      end
      SZ_HALF: begin
        case ({in_signed, out_signed})
          2'b11:   out_word = s16_hi ? S16_MAX : (s16_lo ? S16_MIN : in_word);
          2'b10:   out_word = neg ? ZERO_W : (su16_over ? U16_MAX : in_word);
          default: out_word = u16_over ? U16_MAX : in_word;
        endcase
      end
      default: begin
        // word, only signed to unsigned changes anything
        if (in_signed && !out_signed && neg) begin
          out_word = ZERO_W;
        end
      end
    endcase
  end

endmodule

//--- verification/vlane_ref.svh
/* Testbench helpers for the lane slice: xorshift generator and the reference model of one
   lane element. Include inside a module that already imports vlane_pkg.
*/
`ifndef VLANE_REF_SVH
`define VLANE_REF_SVH

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// expected out_elem word for one lane of one request
function automatic logic [ELEM_W-1:0] lane_expected(
  input alu_op_e           op,
  input sat_op_e           sop,
  input logic              en,               // mask bit of this lane
  input logic [ELEM_W-1:0] a,
  input logic [ELEM_W-1:0] b
);
  logic [ELEM_W-1:0] r;                      // wrapped element result
  logic [3:0]        code;                   // raw opcode bits
  longint            v;                      // result read as a number
  longint            lo;
  longint            hi;
  logic              clamp;                  // 0 for plain word pass
  if (!en) begin
    return a;                                // disabled lane gives a back
  end
  if (op == ALU_ADD) begin
    r = a + b;
  end else if (op == ALU_SUB) begin
    r = a - b;
  end else if (op == ALU_RSUB) begin
    r = b - a;
  end else begin
    r = a;
  end
  code = sop;
  if (code[2]) begin
    v = longint'($signed(r));                // input signed
  end else begin
    v = longint'(r);                         // input unsigned
  end
  clamp = 1'b1;
  lo    = 0;
  hi    = 64'sh7fff_ffff_ffff_ffff;
  case (code[1:0])
    2'b01: begin                             // byte
      lo = code[3] ? -128 : 0;
      hi = code[3] ? 127 : 255;
    end
    2'b10: begin                             // half
      lo = code[3] ? -32768 : 0;
      hi = code[3] ? 32767 : 65535;
    end
    default: begin                           // word, only signed to unsigned floors at 0
      clamp = code[2] & ~code[3];
    end
  endcase
  if (clamp) begin
    if (v < lo) begin
      v = lo;
    end else if (v > hi) begin
      v = hi;
    end
  end
  return v[ELEM_W-1:0];                      // low word, sign-extended for signed targets
endfunction

`endif

//--- verification/vlane_satlanes_tb.sv
/* Testbench for the lane slice. Directed saturate corners, then random ops, masks and
   gaps. Stops at the first mismatch. Expects the fixed two-cycle output latency.
*/
`timescale 1ns/1ps

module vlane_satlanes_tb;

  import vlane_pkg::*;

  `include "vlane_ref.svh"

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;           // ns after rising edge
  localparam int RESET_CYCLES = 8;
  localparam int N_CORNER     = 36;          // 9 sat ops x 4 requests
  localparam int N_RAND       = 200;
  localparam int MAX_GAP      = 3;           // idle cycles between random requests
  localparam int NUM_REQ      = N_CORNER + N_RAND;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_REQ * (MAX_GAP + 1) + 20) * CLK_PERIOD;

  typedef logic [NUM_LANES-1:0][ELEM_W-1:0] vec_word_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              in_valid;
  vec_req_t          in_ctrl;
  lane_req_t         in_elem  [NUM_LANES];
  logic              out_valid;
  logic [ELEM_W-1:0] out_elem [NUM_LANES];

  logic [31:0] rng_state;
  lane_req_t   req_elem [NUM_LANES];         // staged operands for the next send
  vec_word_t   exp_q [$];                    // expected vectors in issue order
  vec_word_t   last_vec;                     // what out_elem must hold now
  logic [1:0]  valid_hist;                   // in_valid at the last two negedges

  sat_op_e legal_ops [9] = '{SAT_U_W, SAT_U_B, SAT_U_H, SAT_S_W, SAT_S_B, SAT_S_H,
                             SAT_SU_W, SAT_SU_B, SAT_SU_H};
  logic [31:0] corner_val [14] = '{32'h0000_007f, 32'h0000_0080, 32'hffff_ff80, 32'hffff_ff7f,
                                   32'h0000_00ff, 32'h0000_0100, 32'h0000_7fff, 32'h0000_8000,
                                   32'h0000_ffff, 32'h0001_0000, 32'hffff_ffff, 32'h0000_0000,
                                   32'h7fff_ffff, 32'h8000_0000};

  vlane_satlanes i_vlane_satlanes (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ctrl   (in_ctrl),
    .in_elem   (in_elem),
    .out_valid (out_valid),
    .out_elem  (out_elem)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // one strobe with the staged operands and its expected vector queued
  task automatic send_req(input alu_op_e op, input sat_op_e sop, input logic [NUM_LANES-1:0] m);
    vec_word_t exp_vec;
    int        i;
    @(posedge clk);
    #(DRIVE_DELAY);
    in_valid       = 1'b1;
    in_ctrl.alu_op = op;
    in_ctrl.sat_op = sop;
    in_ctrl.mask   = m;
    for (i = 0; i < NUM_LANES; i++) begin
      in_elem[i] = req_elem[i];
      exp_vec[i] = lane_expected(op, sop, m[i], req_elem[i].a, req_elem[i].b);
    end
    exp_q.push_back(exp_vec);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      in_valid = 1'b0;
    end
  endtask

  // compare at negedge when all outputs have settled
  always @(negedge clk) begin
    int i;
    if (!rst_n) begin
      valid_hist = 2'b00;
      check_value("out_valid", out_valid, 1'b0);
      for (i = 0; i < NUM_LANES; i++) begin
        check_value($sformatf("out_elem[%0d]", i), out_elem[i], '0);
      end
    end else begin
      check_value("out_valid", out_valid, valid_hist[1]);  // two cycles after the strobe
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("out_valid went high at %0t with no request outstanding", $time);
          stop_run();
        end
        last_vec = exp_q.pop_front();
      end
      for (i = 0; i < NUM_LANES; i++) begin
        check_value($sformatf("out_elem[%0d]", i), out_elem[i], last_vec[i]);  // also hold
      end
      valid_hist = {valid_hist[0], in_valid};
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    stop_run();
  end

  initial begin
    int s;
    int k;
    int i;
    int n;
    logic [31:0] r;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_ctrl    = '0;
    rng_state  = 32'h226e33df;
    last_vec   = '0;                         // out_elem reads zero until the first result
    valid_hist = 2'b00;
    for (i = 0; i < NUM_LANES; i++) begin
      in_elem[i]  = '0;
      req_elem[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    idle_cycles(3);                          // quiet outputs before the first strobe

    // back-to-back saturate corners with the value through a or through b
    for (s = 0; s < 9; s++) begin
      for (k = 0; k < 4; k++) begin
        for (i = 0; i < NUM_LANES; i++) begin
          r = corner_val[(k * NUM_LANES + i) % 14];
          req_elem[i].a = k[0] ? 32'h0 : r;
          req_elem[i].b = k[0] ? r : rand_word();
        end
        send_req(k[0] ? ALU_RSUB : ALU_PASS, legal_ops[s], '1);
      end
    end
    idle_cycles(2);

    // random ops, masks and gaps
    for (n = 0; n < N_RAND; n++) begin
      for (i = 0; i < NUM_LANES; i++) begin
        r = rand_word();
        req_elem[i].a = rand_word();
        req_elem[i].b = rand_word();
        if (r[0]) begin                      // near the byte and half limits
          req_elem[i].a = {{15{r[16]}}, r[16:0]};
        end
        if (r[1]) begin
          req_elem[i].b = {{15{r[31]}}, r[31:15]};
        end
      end
      r = rand_word();
      send_req(alu_op_e'(r[1:0]), legal_ops[r[31:8] % 9], r[7:4]);
      idle_cycles(rand_word() % (MAX_GAP + 1));  // 0 keeps strobes back to back
    end

    idle_cycles(4);                          // last result is out by now
    if (exp_q.size() != 0) begin
      $display("%0d requests never produced out_valid", exp_q.size());
      stop_run();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- vlane_satlanes.f
+incdir+verification
logic/vlane_pkg.sv
logic/vlane_alu.sv
logic/vlane_saturatesize.sv
logic/vlane_lane.sv
logic/vlane_satlanes.sv
verification/vlane_satlanes_tb.sv
